/* hdl/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

  localparam int ROW_CHARS = 16;
  localparam int INIT_CMDS = 4;

  // HD44780 style command codes
  localparam logic [7:0] CMD_FUNC_SET   = 8'h38; // 8-bit bus, 2 lines, 5x7 font
  localparam logic [7:0] CMD_CLEAR      = 8'h01;
  localparam logic [7:0] CMD_ENTRY_MODE = 8'h06; // address increments, no shift
  localparam logic [7:0] CMD_DISPLAY_ON = 8'h0C; // cursor off
  localparam logic [7:0] CMD_LINE1_ADDR = 8'h80;
  localparam logic [7:0] CMD_LINE2_ADDR = 8'hC0; // DDRAM 40h

  // step numbering of one page sequence, setup commands come first
  localparam int STEP_W = 6;
  typedef logic [STEP_W-1:0] step_t;
  localparam step_t LINE1_STEP = step_t'(INIT_CMDS);
  localparam step_t LINE2_STEP = step_t'(INIT_CMDS + ROW_CHARS + 1);
  localparam step_t LAST_STEP  = step_t'(INIT_CMDS + 2 * ROW_CHARS + 1);

  typedef struct packed {
    logic       rs;   // 0 command, 1 character
    logic [7:0] data;
  } lcd_word_t;

  // row 0 and its first character sit in the top bits
  typedef logic [0:1][0:ROW_CHARS-1][7:0] page_text_t;

  // write-only master request, we is implied
  typedef struct packed {
    logic      cyc;
    logic      stb;
    lcd_word_t word;
  } wb_m_t;

endpackage

`default_nettype wire

/* hdl/banner_pkg.sv */
`default_nettype none

package banner_pkg;

  // the two pages shown in turn
  localparam lcd_pkg::page_text_t PAGE_A_TEXT = {
    "  LCD BANNER A  ",
    "  PAGE ONE TEXT "
  };

  localparam lcd_pkg::page_text_t PAGE_B_TEXT = {
    " SECOND SCREEN  ",
    "  PAGE TWO TEXT "
  };

  // enable pacing in sysclk cycles
  // 32768 high plus 32768 low gives one write per 64k cycles
  localparam logic [15:0] EN_HIGH_CYCLES = 16'd32768;
  localparam logic [15:0] EN_LOW_CYCLES  = 16'd32768;

  // full passes a page keeps the bus before handing over
  localparam int unsigned DWELL_PASSES = 8;

  // pass counter type in the arbiter, holds up to 255 passes
  localparam int DWELL_CNT_W = 8;
  typedef logic [DWELL_CNT_W-1:0] dwell_cnt_t;

endpackage

`default_nettype wire

/* hdl/lcd_page_writer.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_page_writer #(
  parameter lcd_pkg::page_text_t TEXT = '0
) (
  input  wire logic          sysclk,
  input  wire logic          rst_n,
  output lcd_pkg::wb_m_t     req,
  input  wire logic          ack
);

  logic              cyc_q;
  logic              stb_q;
  logic              setup_done; // setup commands went out once
  lcd_pkg::step_t    step;
  lcd_pkg::lcd_word_t word;
  logic [3:0]        col;        // character column of the current row

  // decode the step into the word to send
  always_comb begin
    word = '{rs: 1'b0, data: 8'h00};
    col  = 4'd0;
    if (step < lcd_pkg::LINE1_STEP) begin
      case (step[1:0])
        2'd0:    word.data = lcd_pkg::CMD_FUNC_SET;
        2'd1:    word.data = lcd_pkg::CMD_CLEAR;
        2'd2:    word.data = lcd_pkg::CMD_ENTRY_MODE;
        default: word.data = lcd_pkg::CMD_DISPLAY_ON;
      endcase
    end else if (step == lcd_pkg::LINE1_STEP) begin
      word.data = lcd_pkg::CMD_LINE1_ADDR;
    end else if (step < lcd_pkg::LINE2_STEP) begin
      col  = 4'(step - lcd_pkg::LINE1_STEP - lcd_pkg::step_t'(1));
      word = '{rs: 1'b1, data: TEXT[0][col]};
    end else if (step == lcd_pkg::LINE2_STEP) begin
      word.data = lcd_pkg::CMD_LINE2_ADDR;
    end else begin
      col  = 4'(step - lcd_pkg::LINE2_STEP - lcd_pkg::step_t'(1));
      word = '{rs: 1'b1, data: TEXT[1][col]};
    end
  end

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      cyc_q      <= 1'b0;
      stb_q      <= 1'b0;
      step       <= '0;
      setup_done <= 1'b0;
    end else if (!cyc_q) begin
      // new pass, skip setup once it has been sent
      cyc_q <= 1'b1;
      stb_q <= 1'b1;
      step  <= setup_done ? lcd_pkg::LINE1_STEP : '0;
    end else if (stb_q && ack) begin
      stb_q <= 1'b0; // one idle cycle before the next word
      if (step == lcd_pkg::LAST_STEP) begin
        cyc_q      <= 1'b0; // end of pass
        setup_done <= 1'b1;
      end else begin
        step <= step + lcd_pkg::step_t'(1);
      end
    end else if (!stb_q) begin
      stb_q <= 1'b1;
    end
  end

  assign req = '{cyc: cyc_q, stb: stb_q, word: word};

  // strobe only inside a cycle
  a_stb_in_cyc: assert property (
    @(posedge sysclk) disable iff (!rst_n) req.stb |-> req.cyc
  );

  // a waiting request keeps its word until the ack comes back
  a_hold_req: assert property (
    @(posedge sysclk) disable iff (!rst_n)
    req.stb && !ack |=> req.stb && req.cyc && $stable(req.word)
  );

endmodule

`default_nettype wire

/* hdl/lcd_page_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_page_arbiter #(
  parameter int unsigned DWELL = banner_pkg::DWELL_PASSES
) (
  input  wire logic            sysclk,
  input  wire logic            rst_n,
  input  wire lcd_pkg::wb_m_t  req_a,
  input  wire lcd_pkg::wb_m_t  req_b,
  output logic                 ack_a,
  output logic                 ack_b,
  output lcd_pkg::wb_m_t       bus,
  input  wire logic            bus_ack
);

  logic                   grant_b;  // 0 page A owns the bus
  logic                   cyc_seen; // granted cyc one cycle back
  logic                   pass_end;
  banner_pkg::dwell_cnt_t pass_cnt;

  // forward the owner while the other side waits with its request held
  assign bus   = grant_b ? req_b : req_a;
  assign ack_a = bus_ack && !grant_b;
  assign ack_b = bus_ack && grant_b;

  // falling cyc marks a finished pass with cyc low in this cycle
  assign pass_end = cyc_seen && !bus.cyc;

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      cyc_seen <= 1'b0;
    end else begin
      cyc_seen <= bus.cyc;
    end
  end

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      grant_b  <= 1'b0; // page A first
      pass_cnt <= '0;
    end else if (pass_end) begin
      if (pass_cnt == banner_pkg::dwell_cnt_t'(DWELL - 1)) begin
        grant_b  <= !grant_b; // hand over while the owner is idle
        pass_cnt <= '0;
      end else begin
        pass_cnt <= pass_cnt + banner_pkg::dwell_cnt_t'(1);
      end
    end
  end

  a_one_ack: assert property (
    @(posedge sysclk) disable iff (!rst_n) !(ack_a && ack_b)
  );

  // the owner never loses the bus in the middle of a pass
  a_grant_idle: assert property (
    @(posedge sysclk) disable iff (!rst_n) $changed(grant_b) |-> !$past(bus.cyc)
  );

endmodule

`default_nettype wire

/* hdl/lcd_port_driver.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_port_driver #(
  parameter logic [15:0] EN_HIGH = banner_pkg::EN_HIGH_CYCLES,
  parameter logic [15:0] EN_LOW  = banner_pkg::EN_LOW_CYCLES
) (
  input  wire logic            sysclk,
  input  wire logic            rst_n,
  input  wire lcd_pkg::wb_m_t  bus,
  output logic                 ack,
  output logic                 lcd_en,
  output logic                 lcd_rs,
  output logic [7:0]           lcd_data
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HIGH,
    ST_LOW,
    ST_ACK
  } state_t;

  state_t             state;
  logic [15:0]        cnt;    // cycles left in the current phase
  lcd_pkg::lcd_word_t word_q; // drives the LCD pins

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= ST_IDLE;
      cnt    <= '0;
      word_q <= '0;
    end else begin
      case (state)
        ST_IDLE: if (bus.cyc && bus.stb) begin
          word_q <= bus.word; // pins settle as enable rises
          cnt    <= EN_HIGH - 16'd1;
          state  <= ST_HIGH;
        end
        ST_HIGH: if (cnt == '0) begin
          cnt   <= EN_LOW - 16'd1;
          state <= ST_LOW; // LCD latches on this edge
        end else begin
          cnt <= cnt - 16'd1;
        end
        ST_LOW: if (cnt == '0) begin
          state <= ST_ACK;
        end else begin
          cnt <= cnt - 16'd1;
        end
        default: state <= ST_IDLE; // single ack cycle
      endcase
    end
  end

  assign lcd_en   = (state == ST_HIGH);
  assign ack      = (state == ST_ACK);
  assign lcd_rs   = word_q.rs;
  assign lcd_data = word_q.data;

  a_pins_stable: assert property (
    @(posedge sysclk) disable iff (!rst_n)
    lcd_en && $past(lcd_en) |-> $stable({lcd_rs, lcd_data})
  );

endmodule

`default_nettype wire

/* hdl/lcd_banner_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_banner_top #(
  parameter logic [15:0] EN_HIGH = banner_pkg::EN_HIGH_CYCLES,
  parameter logic [15:0] EN_LOW  = banner_pkg::EN_LOW_CYCLES,
  parameter int unsigned DWELL   = banner_pkg::DWELL_PASSES
) (
  input  wire logic       sysclk,
  input  wire logic       rst_n,
  output logic            lcd_en,
  output logic            lcd_rs,
  output logic            lcd_rw,
  output logic [7:0]      lcd_data,
  output logic            lcd_on,
  output logic            lcd_blon
);

  lcd_pkg::wb_m_t req_a;
  lcd_pkg::wb_m_t req_b;
  lcd_pkg::wb_m_t bus;
  logic           ack_a;
  logic           ack_b;
  logic           bus_ack;

  // write only, panel and backlight always on
  assign lcd_rw   = 1'b0;
  assign lcd_on   = 1'b1;
  assign lcd_blon = 1'b1;

  lcd_page_writer #(.TEXT(banner_pkg::PAGE_A_TEXT)) page_a (
    .sysclk (sysclk),
    .rst_n  (rst_n),
    .req    (req_a),
    .ack    (ack_a)
  );

  lcd_page_writer #(.TEXT(banner_pkg::PAGE_B_TEXT)) page_b (
    .sysclk (sysclk),
    .rst_n  (rst_n),
    .req    (req_b),
    .ack    (ack_b)
  );

  lcd_page_arbiter #(.DWELL(DWELL)) page_arb (
    .sysclk (sysclk), .rst_n (rst_n), .req_a (req_a), .req_b (req_b),
    .ack_a  (ack_a), .ack_b (ack_b), .bus (bus), .bus_ack (bus_ack)
  );

  lcd_port_driver #(.EN_HIGH(EN_HIGH), .EN_LOW(EN_LOW)) port_drv (
    .sysclk (sysclk), .rst_n (rst_n), .bus (bus), .ack (bus_ack),
    .lcd_en (lcd_en), .lcd_rs (lcd_rs), .lcd_data (lcd_data)
  );

endmodule

`default_nettype wire

/* dv/lcd_banner_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_banner_tb;

  localparam int TB_EN_HIGH = 2;
  localparam int TB_EN_LOW  = 2;
  localparam int TB_DWELL   = 2;
  localparam int CLK_PERIOD = 10;
  // 12 passes of 39 writes with at most EN_HIGH + EN_LOW + 3 cycles each
  localparam int WATCHDOG_CYCLES = 39 * (TB_EN_HIGH + TB_EN_LOW + 3) * 12 + 500;

  logic       sysclk;
  logic       rst_n;
  logic       lcd_en;
  logic       lcd_rs;
  logic       lcd_rw;
  logic [7:0] lcd_data;
  logic       lcd_on;
  logic       lcd_blon;

  lcd_pkg::lcd_word_t words_q[$]; // latched words in LCD order
  lcd_pkg::lcd_word_t mon_word;
  int                 words_seen;
  int                 pulse_cnt;   // enable pulses measured by the timing checker
  int                 n_checks;
  int                 n_errors;

  // enable timing checker state
  int         hi_cnt;
  int         lo_cnt;
  logic       prev_en;
  logic       seen_fall;
  logic [8:0] held;

  lcd_banner_top #(
    .EN_HIGH (16'(TB_EN_HIGH)),
    .EN_LOW  (16'(TB_EN_LOW)),
    .DWELL   (TB_DWELL)
  ) lcd_banner_top_i (
    .sysclk   (sysclk),
    .rst_n    (rst_n),
    .lcd_en   (lcd_en),
    .lcd_rs   (lcd_rs),
    .lcd_rw   (lcd_rw),
    .lcd_data (lcd_data),
    .lcd_on   (lcd_on),
    .lcd_blon (lcd_blon)
  );

  always #(CLK_PERIOD / 2) sysclk = ~sysclk;

  // the LCD latches on the falling enable edge
  always @(negedge lcd_en) begin
    if (rst_n) begin
      mon_word.rs   = lcd_rs;
      mon_word.data = lcd_data;
      words_q.push_back(mon_word);
      words_seen++;
    end
  end

  // pulse width, gap and pin stability sampled away from the active edge
  always @(negedge sysclk) begin
    if (!rst_n) begin
      hi_cnt    = 0;
      lo_cnt    = 0;
      prev_en   = 1'b0;
      seen_fall = 1'b0;
    end else begin
      if (lcd_en) begin
        if (prev_en) begin
          n_checks++;
          assert ({lcd_rs, lcd_data} === held) else begin
            n_errors++;
            $display("FAILED at %0t: lcd_rs/lcd_data expected %03h got %03h (enable high)",
                     $time, held, {lcd_rs, lcd_data});
          end
        end else begin
          if (seen_fall) begin
            n_checks++;
            assert (lo_cnt >= TB_EN_LOW) else begin
              n_errors++;
              $display("FAILED at %0t: lcd_en low cycles expected >= %0d got %0d",
                       $time, TB_EN_LOW, lo_cnt);
            end
          end
          held   = {lcd_rs, lcd_data};
          hi_cnt = 0;
        end
        hi_cnt++;
      end else begin
        if (prev_en) begin
          n_checks++;
          assert (hi_cnt == TB_EN_HIGH) else begin
            n_errors++;
            $display("FAILED at %0t: lcd_en high cycles expected %0d got %0d",
                     $time, TB_EN_HIGH, hi_cnt);
          end
          pulse_cnt++;
          seen_fall = 1'b1;
          lo_cnt    = 0;
        end
        lo_cnt++;
      end
      prev_en = lcd_en;
    end
  end

  task automatic compare_bits(input string sig, input string what,
                              input logic [7:0] got, input logic [7:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("FAILED at %0t: %s expected %02h got %02h (%s)", $time, sig, exp, got, what);
    end
  endtask

  // next latched word against the expected one
  task automatic expect_word(input logic rs, input logic [7:0] data, input string what);
    lcd_pkg::lcd_word_t got;
    while (words_q.size() == 0) @(posedge sysclk);
    got = words_q.pop_front();
    compare_bits("lcd_rs", what, {7'd0, got.rs}, {7'd0, rs});
    compare_bits("lcd_data", what, got.data, data);
  endtask

  task automatic expect_setup(input string page);
    expect_word(1'b0, lcd_pkg::CMD_FUNC_SET, {page, " function set"});
    expect_word(1'b0, lcd_pkg::CMD_CLEAR, {page, " clear"});
    expect_word(1'b0, lcd_pkg::CMD_ENTRY_MODE, {page, " entry mode"});
    expect_word(1'b0, lcd_pkg::CMD_DISPLAY_ON, {page, " display on"});
  endtask

  task automatic expect_row(input lcd_pkg::page_text_t text, input int row,
                            input string page);
    for (int i = 0; i < lcd_pkg::ROW_CHARS; i++) begin
      expect_word(1'b1, text[row][i], $sformatf("%s row %0d char %0d", page, row, i));
    end
  endtask

  task automatic expect_pass(input lcd_pkg::page_text_t text, input string page);
    expect_word(1'b0, lcd_pkg::CMD_LINE1_ADDR, {page, " line 1 address"});
    expect_row(text, 0, page);
    expect_word(1'b0, lcd_pkg::CMD_LINE2_ADDR, {page, " line 2 address"});
    expect_row(text, 1, page);
  endtask

  task automatic apply_reset;
    repeat (5) @(posedge sysclk);
    #1 rst_n = 1'b1;
  endtask

  task automatic test_idle_outputs;
    compare_bits("lcd_en", "after reset", {7'd0, lcd_en}, 8'h00);
    compare_bits("lcd_rw", "after reset", {7'd0, lcd_rw}, 8'h00);
    compare_bits("lcd_on", "after reset", {7'd0, lcd_on}, 8'h01);
    compare_bits("lcd_blon", "after reset", {7'd0, lcd_blon}, 8'h01);
    compare_bits("lcd_rs", "after reset", {7'd0, lcd_rs}, 8'h00);
    compare_bits("lcd_data", "after reset", lcd_data, 8'h00);
  endtask

  task automatic test_first_words;
    expect_setup("page A");
    expect_word(1'b0, lcd_pkg::CMD_LINE1_ADDR, "page A line 1 address");
  endtask

  // rest of the first pass and then a pass with no setup
  task automatic test_page_a_passes;
    expect_row(banner_pkg::PAGE_A_TEXT, 0, "page A");
    expect_word(1'b0, lcd_pkg::CMD_LINE2_ADDR, "page A line 2 address");
    expect_row(banner_pkg::PAGE_A_TEXT, 1, "page A");
    expect_pass(banner_pkg::PAGE_A_TEXT, "page A");
  endtask

  task automatic test_page_b_turn;
    expect_setup("page B");
    for (int p = 0; p < TB_DWELL; p++) expect_pass(banner_pkg::PAGE_B_TEXT, "page B");
    expect_word(1'b0, lcd_pkg::CMD_LINE1_ADDR, "page A resumes");
  endtask

  task automatic test_enable_timing;
    @(negedge sysclk);
    #1;
    n_checks++;
    assert (pulse_cnt > 0) else begin
      n_errors++;
      $display("no enable pulse was measured by the timing checker");
    end
    n_checks++;
    assert (pulse_cnt == words_seen) else begin
      n_errors++;
      $display("FAILED at %0t: pulse count expected %0d got %0d",
               $time, words_seen, pulse_cnt);
    end
  endtask

  task automatic test_reset_mid_pass;
    for (int i = 0; i < 3; i++) begin
      expect_word(1'b1, banner_pkg::PAGE_A_TEXT[0][i], $sformatf("page A char %0d", i));
    end
    wait (lcd_en === 1'b1);
    @(posedge sysclk);
    #1 rst_n = 1'b0; // enable is still high here
    #1;
    compare_bits("lcd_en", "during reset", {7'd0, lcd_en}, 8'h00);
    repeat (5) @(posedge sysclk);
    words_q.delete();
    #1 rst_n = 1'b1;
    compare_bits("lcd_en", "after mid-pass reset", {7'd0, lcd_en}, 8'h00);
    expect_setup("page A after reset");
    expect_word(1'b0, lcd_pkg::CMD_LINE1_ADDR, "page A line 1 after reset");
    expect_row(banner_pkg::PAGE_A_TEXT, 0, "page A after reset");
  endtask

  initial begin
    sysclk     = 1'b0;
    rst_n      = 1'b0;
    n_checks   = 0;
    n_errors   = 0;
    words_seen = 0;
    pulse_cnt  = 0;
    apply_reset();
    test_idle_outputs();
    test_first_words();
    test_page_a_passes();
    test_page_b_turn();
    test_enable_timing();
    test_reset_mid_pass();
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests finished, checks %0d, errors %0d",
             n_checks, n_errors);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
hdl/lcd_pkg.sv
hdl/banner_pkg.sv
hdl/lcd_page_writer.sv
hdl/lcd_page_arbiter.sv
hdl/lcd_port_driver.sv
hdl/lcd_banner_top.sv
dv/lcd_banner_tb.sv

/* run.sh */
#!/bin/sh
# build the LCD banner testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f files.f --top-module lcd_banner_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vlcd_banner_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the result is the pass line on its own
if echo "$out" | grep -q '^=== PASS ===$'; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
